//--- compile.f
src/isa_pkg.sv
src/control_pkg.sv
src/instr_register.sv
src/instr_decoder.sv
src/branch_condition.sv
src/control_sequencer.sv
src/cpu_control.sv
verif/cpu_control_sva.sv
verif/cpu_control_tb.sv

//--- Bender.yml
package:
  name: cpu_control

sources:
  - files:
      - src/isa_pkg.sv
      - src/control_pkg.sv
      - src/instr_register.sv
      - src/instr_decoder.sv
      - src/branch_condition.sv
      - src/control_sequencer.sv
      - src/cpu_control.sv
  - target: test
    files:
      - verif/cpu_control_sva.sv
      - verif/cpu_control_tb.sv

//--- verif/cpu_control_tb.sv
`timescale 1ns/1ns

module cpu_control_tb;

  localparam int NUM_INSTR  = 200;
  localparam int CLK_PERIOD = 10;
  localparam int TIMEOUT_NS = (NUM_INSTR * 12 + 50) * CLK_PERIOD;

  logic                    clock;
  logic                    reset_n;
  isa_pkg::word_t          bus_rdata;
  isa_pkg::ccr_t           ccr;
  logic                    bus_wait;
  control_pkg::align_t     bus_align;
  control_pkg::ctrl_word_t ctrl;
  control_pkg::bus_req_t   bus;
  logic                    halted;

  logic [31:0]         lfsr;
  isa_pkg::ccr_t       cur_ccr;    // held for one whole instruction
  control_pkg::align_t cur_align;
  string               test_name;
  int                  checks;
  int                  mismatches;

  cpu_control dut_i (
    .clock     (clock),
    .reset_n   (reset_n),
    .bus_rdata (bus_rdata),
    .ccr       (ccr),
    .bus_wait  (bus_wait),
    .bus_align (bus_align),
    .ctrl      (ctrl),
    .bus       (bus),
    .halted    (halted)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the DUT did not get through %0d instructions in time", NUM_INSTR);
    $display("checks: %0d, mismatches: %0d", checks, mismatches);
    $display("ERRORS FOUND");
    $finish;
  end

  // fibonacci lfsr x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  // ccr is carry, negative, overflow, zero
  function automatic logic branch_taken(input isa_pkg::cond_t cond, input isa_pkg::ccr_t flags);
    logic c;
    logic n;
    logic v;
    logic z;
    c = flags[3];
    n = flags[2];
    v = flags[1];
    z = flags[0];
    case (cond)
      4'h0: return 1'b1;
      4'h1: return z;
      4'h2: return !z;
      4'h3: return !c && !z;
      4'h4: return !z && (n == v);
      4'h5: return n == v;
      4'h6: return z || (n != v);
      4'h7: return n != v;
      4'h8: return !c;
      4'h9: return c;
      4'ha: return c || z;
      default: return 1'b0;  // brn
    endcase
  endfunction

  // size 0 long, 1 half, 2 byte
  function automatic control_pkg::byteen_t expected_lanes(input int size_sel,
                                                          input control_pkg::align_t align);
    if (size_sel == 0)
      return 4'b1111;
    if (size_sel == 1)
      return (align < 2'd2) ? 4'b1100 : 4'b0011;
    case (align)
      2'd0: return 4'b1000;
      2'd1: return 4'b0100;
      2'd2: return 4'b0010;
      default: return 4'b0001;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH %s %s: expected %0h, actual %0h at %0t",
               test_name, name, exp, act, $time);
    end
  endtask

  task automatic check_cycle(input string what, input logic exp_ir,
                             input control_pkg::pcsel_t exp_pc,
                             input control_pkg::reg_write_t exp_rw,
                             input logic exp_rd, input logic exp_wr,
                             input control_pkg::byteen_t exp_be, input logic exp_halt);
    check_val({what, " ir_write"}, exp_ir, ctrl.ir_write);
    check_val({what, " pcsel"}, exp_pc, ctrl.pcsel);
    check_val({what, " reg_write"}, exp_rw, ctrl.reg_write);
    check_val({what, " read"}, exp_rd, bus.read);
    check_val({what, " write"}, exp_wr, bus.write);
    check_val({what, " byteenable"}, exp_be, bus.byteenable);
    check_val({what, " halted"}, exp_halt, halted);
  endtask

  // inputs change 1 ns after the edge, outputs are sampled at the falling edge
  task automatic next_cycle(input logic wait_v, input isa_pkg::word_t rdata_v);
    @(posedge clock);
    #1;
    bus_wait  = wait_v;
    bus_rdata = rdata_v;
    ccr       = cur_ccr;
    bus_align = cur_align;
    @(negedge clock);
  endtask

  task automatic apply_reset();
    test_name = "reset";
    for (int i = 0; i < 3; i++) begin
      @(posedge clock);
      #1;
      reset_n  = 1'b0;
      bus_wait = 1'b0;
      @(negedge clock);
      check_val("ir_write", 1'b0, ctrl.ir_write);
      check_val("ccr_write", 1'b0, ctrl.ccr_write);
      check_val("reg_write", control_pkg::REG_WRITE_NONE, ctrl.reg_write);
      check_val("read", 1'b0, bus.read);
      check_val("write", 1'b0, bus.write);
      check_val("byteenable", 4'b1111, bus.byteenable);
      check_val("halted", 1'b0, halted);
    end
    @(posedge clock);
    #1;
    reset_n = 1'b1;
    @(negedge clock);
    check_cycle("vector", 1'b0, control_pkg::PCSEL_VECTOR, control_pkg::REG_WRITE_NONE,
                1'b0, 1'b0, 4'b1111, 1'b0);
  endtask

  task automatic run_instr(input int idx);
    int                     kind;
    int                     fetch_waits;
    int                     mem_waits;
    int                     size_sel;
    isa_pkg::mode_t         mode;
    isa_pkg::opcode_t       op;
    isa_pkg::reg_idx_t      ra;
    isa_pkg::reg_idx_t      rb;
    isa_pkg::reg_idx_t      rc;
    logic [5:0]             low;
    isa_pkg::word_t         word;
    string                  label;
    control_pkg::regsel_t   exp_regsel;
    control_pkg::alu_func_t exp_alu;
    control_pkg::alu2sel_t  exp_alu2sel;
    control_pkg::pcsel_t    exp_pc;
    control_pkg::byteen_t   lanes;
    logic                   is_load;

    kind        = int'(take_bits(4));
    ra          = 5'(take_bits(5));
    rb          = 5'(take_bits(5));
    rc          = 5'(take_bits(5));
    low         = 6'(take_bits(6));
    fetch_waits = int'(take_bits(2));
    mem_waits   = int'(take_bits(2));
    size_sel    = int'(take_bits(2)) % 3;
    cur_ccr     = 4'(take_bits(4));
    cur_align   = 2'(take_bits(2));
    mode        = isa_pkg::MODE_REG;
    exp_regsel  = control_pkg::REGSEL_ALU;
    op          = isa_pkg::OP_NOP;

    case (kind)
      0: label = "nop";
      1: begin op = isa_pkg::OP_CMP; label = "cmp"; end
      2: begin op = isa_pkg::OP_INC; label = "inc"; end
      3: begin op = isa_pkg::OP_DEC; label = "dec"; end
      4: begin op = isa_pkg::OP_MOV; label = "mov"; exp_regsel = control_pkg::REGSEL_REG2; end
      5: begin op = isa_pkg::OP_COM; label = "com"; exp_regsel = control_pkg::REGSEL_COM; end
      6: begin op = isa_pkg::OP_NEG; label = "neg"; exp_regsel = control_pkg::REGSEL_NEG; end
      7: begin op = 8'h20 | 8'(take_bits(4)); label = "alu3"; end
      8: begin mode = isa_pkg::MODE_IMM; op = 8'(take_bits(4) % 12); label = "branch"; end
      9: begin
        mode       = isa_pkg::MODE_IMM;
        op         = isa_pkg::OP_LDIS;
        label      = "ldis";
        exp_regsel = control_pkg::REGSEL_IMMS;
      end
      10: begin
        mode       = isa_pkg::MODE_IMM;
        op         = isa_pkg::OP_LDIU;
        label      = "ldiu";
        exp_regsel = control_pkg::REGSEL_IMMU;
      end
      11: begin mode = isa_pkg::MODE_REGIND; op = isa_pkg::OP_LDA; label = "lda"; end
      12: begin mode = isa_pkg::MODE_REGIND; op = isa_pkg::OP_JMP; label = "jmp"; end
      13: begin mode = isa_pkg::MODE_REGIND; op = 8'(size_sel * 2 + 1); label = "load"; end
      14: begin mode = isa_pkg::MODE_REGIND; op = 8'(size_sel * 2); label = "store"; end
      default: begin
        label = "undefined";
        if (take_bits(1) == 1) begin
          mode = 3'd4;  // old direct mode
          op   = 8'(take_bits(8));
        end else begin
          op = 8'h05;   // hole in register mode
        end
      end
    endcase

    word      = {mode, op, ra, rb, rc, low};
    test_name = $sformatf("instr %0d %s", idx, label);
    exp_alu   = control_pkg::ALU_ADD;
    if (kind == 1 || kind == 3)
      exp_alu = control_pkg::ALU_SUB;
    if (kind == 7)
      exp_alu = op[2:0];

    // fetch, the word is on the bus from the first wait-free cycle on
    for (int i = 0; i < fetch_waits; i++) begin
      next_cycle(1'b1, ~word);
      check_cycle("fetch wait", 1'b0, control_pkg::PCSEL_HOLD, control_pkg::REG_WRITE_NONE,
                  1'b1, 1'b0, 4'b1111, 1'b0);
    end
    next_cycle(1'b0, word);
    check_cycle("fetch", 1'b0, control_pkg::PCSEL_HOLD, control_pkg::REG_WRITE_NONE,
                1'b1, 1'b0, 4'b1111, 1'b0);
    check_val("fetch addrsel", 1'b0, bus.addrsel);  // fetch reads at the pc
    next_cycle(1'b0, word);
    check_cycle("fetch latch", 1'b1, control_pkg::PCSEL_HOLD, control_pkg::REG_WRITE_NONE,
                1'b1, 1'b0, 4'b1111, 1'b0);
    next_cycle(1'b0, ~word);
    check_cycle("pc increment", 1'b0, control_pkg::PCSEL_INC, control_pkg::REG_WRITE_NONE,
                1'b0, 1'b0, 4'b1111, 1'b0);

    case (kind)
      0, 1, 4, 5, 6, 9, 10: begin
        next_cycle(1'b0, ~word);
        check_cycle("eval", 1'b0, control_pkg::PCSEL_HOLD,
                    (kind <= 1) ? control_pkg::REG_WRITE_NONE : control_pkg::REG_WRITE_DW,
                    1'b0, 1'b0, 4'b1111, 1'b0);
        check_val("ccr_write", kind == 1, ctrl.ccr_write);
        if (kind == 1)
          check_val("alu_func", exp_alu, ctrl.alu_func);
        if (kind >= 4) begin
          check_val("regsel", exp_regsel, ctrl.regsel);
          check_val("reg_write_addr", ra, ctrl.reg_write_addr);
        end
      end
      8: begin
        exp_pc = branch_taken(op[3:0], cur_ccr) ? control_pkg::PCSEL_REL
                                                : control_pkg::PCSEL_HOLD;
        next_cycle(1'b0, ~word);
        check_cycle("branch", 1'b0, exp_pc, control_pkg::REG_WRITE_NONE,
                    1'b0, 1'b0, 4'b1111, 1'b0);
      end
      2, 3, 7, 11, 12: begin
        if (kind == 7)
          exp_alu2sel = control_pkg::ALU2SEL_REG;  // rb op rc
        else if (kind >= 11)
          exp_alu2sel = control_pkg::ALU2SEL_IND;  // rb plus offset
        else
          exp_alu2sel = control_pkg::ALU2SEL_ONE;
        next_cycle(1'b0, ~word);
        check_cycle("eval step 0", 1'b0, control_pkg::PCSEL_HOLD,
                    control_pkg::REG_WRITE_NONE, 1'b0, 1'b0, 4'b1111, 1'b0);
        next_cycle(1'b0, ~word);
        check_cycle("eval step 1", 1'b0,
                    (kind == 12) ? control_pkg::PCSEL_ALU : control_pkg::PCSEL_HOLD,
                    (kind == 12) ? control_pkg::REG_WRITE_NONE : control_pkg::REG_WRITE_DW,
                    1'b0, 1'b0, 4'b1111, 1'b0);
        check_val("reg_read_addr1", (kind == 7 || kind >= 11) ? rb : ra, ctrl.reg_read_addr1);
        if (kind == 7)
          check_val("reg_read_addr2", rc, ctrl.reg_read_addr2);
        check_val("alu_func", exp_alu, ctrl.alu_func);
        check_val("alu2sel", exp_alu2sel, ctrl.alu2sel);
        if (kind != 12) begin
          check_val("regsel", control_pkg::REGSEL_ALU, ctrl.regsel);
          check_val("reg_write_addr", ra, ctrl.reg_write_addr);
        end
      end
      13, 14: begin
        is_load = (kind == 13);
        lanes   = expected_lanes(size_sel, cur_align);
        next_cycle(1'b0, ~word);
        check_cycle("address", 1'b0, control_pkg::PCSEL_HOLD, control_pkg::REG_WRITE_NONE,
                    1'b0, 1'b0, 4'b1111, 1'b0);
        check_val("base register", rb, ctrl.reg_read_addr1);
        check_val("alu2sel", control_pkg::ALU2SEL_IND, ctrl.alu2sel);
        next_cycle(1'b0, ~word);
        check_cycle("mar load", 1'b0, control_pkg::PCSEL_HOLD, control_pkg::REG_WRITE_NONE,
                    1'b0, 1'b0, 4'b1111, 1'b0);
        check_val("marsel", control_pkg::MARSEL_ALU, ctrl.marsel);
        for (int i = 0; i < mem_waits; i++) begin
          next_cycle(1'b1, ~word);
          check_cycle("access wait", 1'b0, control_pkg::PCSEL_HOLD,
                      control_pkg::REG_WRITE_NONE, is_load, !is_load, lanes, 1'b0);
        end
        next_cycle(1'b0, ~word);
        check_cycle("access", 1'b0, control_pkg::PCSEL_HOLD, control_pkg::REG_WRITE_NONE,
                    is_load, !is_load, lanes, 1'b0);
        check_val("access addrsel", 1'b1, bus.addrsel);  // data access goes through mar
        check_val("mdrsel", is_load ? control_pkg::MDRSEL_BUS : control_pkg::MDRSEL_REG,
                  ctrl.mdrsel);
        next_cycle(1'b0, ~word);
        check_cycle("writeback", 1'b0, control_pkg::PCSEL_HOLD,
                    is_load ? control_pkg::REG_WRITE_DW : control_pkg::REG_WRITE_NONE,
                    1'b0, 1'b0, 4'b1111, 1'b0);
        if (is_load) begin
          check_val("regsel", control_pkg::REGSEL_MDR, ctrl.regsel);
          check_val("reg_write_addr", ra, ctrl.reg_write_addr);
        end
      end
      default: begin
        next_cycle(1'b0, ~word);
        check_cycle("undefined", 1'b0, control_pkg::PCSEL_HOLD, control_pkg::REG_WRITE_NONE,
                    1'b0, 1'b0, 4'b1111, 1'b0);
        for (int i = 0; i < 4; i++) begin
          next_cycle(1'(take_bits(1)), ~word);  // bus_wait must not matter here
          check_cycle("fault", 1'b0, control_pkg::PCSEL_HOLD, control_pkg::REG_WRITE_NONE,
                      1'b0, 1'b0, 4'b1111, 1'b1);
        end
        apply_reset();  // only a reset leaves the fault state
      end
    endcase
  endtask

  initial begin
    reset_n    = 1'b0;
    bus_rdata  = '0;
    ccr        = '0;
    bus_wait   = 1'b0;
    bus_align  = '0;
    cur_ccr    = '0;
    cur_align  = '0;
    lfsr       = 32'h4a4d992c;
    checks     = 0;
    mismatches = 0;
    test_name  = "start";

    apply_reset();
    for (int i = 0; i < NUM_INSTR; i++)
      run_instr(i);

    $display("checks: %0d, mismatches: %0d", checks, mismatches);
    if (mismatches == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- verif/cpu_control_sva.sv
`timescale 1ns/1ns

module control_sequencer_sva (
  input logic                    clock,
  input logic                    reset_n,
  input logic                    bus_wait,
  input control_pkg::ctrl_word_t ctrl,
  input control_pkg::bus_req_t   bus
);

  ir_write_single: assert property (@(posedge clock) disable iff (!reset_n)
    ctrl.ir_write |=> !ctrl.ir_write)
    else $error("ir_write asserted for more than one cycle");

  read_write_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
    !(bus.read && bus.write))
    else $error("bus read and write asserted together");

  // fetch step 1 keeps read only while the ir latches
  read_held: assert property (@(posedge clock) disable iff (!reset_n)
    (bus.read && bus_wait && !ctrl.ir_write) |=> bus.read)
    else $error("bus read dropped while bus_wait was high");

  write_held: assert property (@(posedge clock) disable iff (!reset_n)
    (bus.write && bus_wait) |=> bus.write)
    else $error("bus write dropped while bus_wait was high");

endmodule

bind control_sequencer control_sequencer_sva sva_i (
  .clock    (clock),
  .reset_n  (reset_n),
  .bus_wait (bus_wait),
  .ctrl     (ctrl),
  .bus      (bus)
);

//--- src/cpu_control.sv
`timescale 1ns/1ns

module cpu_control (
  input  logic                    clock,
  input  logic                    reset_n,
  input  isa_pkg::word_t          bus_rdata,
  input  isa_pkg::ccr_t           ccr,
  input  logic                    bus_wait,
  input  control_pkg::align_t     bus_align,
  output control_pkg::ctrl_word_t ctrl,
  output control_pkg::bus_req_t   bus,
  output logic                    halted
);

  isa_pkg::instr_fields_t fields;
  control_pkg::decode_t   decode;
  logic                   taken;

  instr_register instr_register_i (
    .clock     (clock),
    .reset_n   (reset_n),
    .bus_rdata (bus_rdata),
    .ir_write  (ctrl.ir_write),
    .fields    (fields)
  );

  instr_decoder instr_decoder_i (
    .fields (fields),
    .decode (decode)
  );

  branch_condition branch_condition_i (
    .cond  (decode.cond),
    .ccr   (ccr),
    .taken (taken)
  );

  control_sequencer control_sequencer_i (
    .clock     (clock),
    .reset_n   (reset_n),
    .fields    (fields),
    .decode    (decode),
    .taken     (taken),
    .bus_wait  (bus_wait),
    .bus_align (bus_align),
    .ctrl      (ctrl),
    .bus       (bus),
    .halted    (halted)
  );

endmodule

//--- src/control_sequencer.sv
`timescale 1ns/1ns

module control_sequencer (
  input  logic                   clock,
  input  logic                   reset_n,
  input  isa_pkg::instr_fields_t fields,
  input  control_pkg::decode_t   decode,
  input  logic                   taken,
  input  logic                   bus_wait,
  input  control_pkg::align_t    bus_align,
  output control_pkg::ctrl_word_t ctrl,
  output control_pkg::bus_req_t  bus,
  output logic                   halted
);

  control_pkg::ctrl_state_t state, state_next;
  control_pkg::step_t       step, step_next;
  control_pkg::byteen_t     lanes;
  logic                     done;  // instruction finished, back to fetch

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= control_pkg::RESET;
      step  <= '0;
    end else begin
      state <= state_next;
      step  <= step_next;
    end
  end

  // byte lanes from address alignment, msb lane is the lowest address
  always_comb begin
    case (decode.size)
      control_pkg::HALF: lanes = bus_align[1] ? 4'b0011 : 4'b1100;
      control_pkg::BYTE: lanes = 4'b1000 >> bus_align;
      default:           lanes = 4'b1111;
    endcase
  end

  assign halted = (state == control_pkg::FAULT);

  always_comb begin
    state_next = state;
    step_next  = step;
    done       = 1'b0;

    ctrl.ir_write       = 1'b0;
    ctrl.ccr_write      = 1'b0;
    ctrl.alu_func       = control_pkg::ALU_ADD;
    ctrl.alu2sel        = control_pkg::ALU2SEL_REG;
    ctrl.regsel         = control_pkg::REGSEL_ALU;
    ctrl.reg_read_addr1 = fields.ra;
    ctrl.reg_read_addr2 = fields.rb;
    ctrl.reg_write_addr = fields.ra;
    ctrl.reg_write      = control_pkg::REG_WRITE_NONE;
    ctrl.mdrsel         = control_pkg::MDRSEL_HOLD;
    ctrl.marsel         = control_pkg::MARSEL_HOLD;
    ctrl.pcsel          = control_pkg::PCSEL_HOLD;
    bus.read            = 1'b0;
    bus.write           = 1'b0;
    bus.addrsel         = 1'b0;
    bus.byteenable      = 4'b1111;

    case (state)
      control_pkg::RESET: begin
        ctrl.pcsel = control_pkg::PCSEL_VECTOR;  // pc <= exception vector
        state_next = control_pkg::FETCH;
        step_next  = '0;
      end
      control_pkg::FETCH: begin
        case (step)
          3'd0: begin
            bus.read = 1'b1;
            if (!bus_wait)
              step_next = 3'd1;
          end
          3'd1: begin
            bus.read      = 1'b1;  // keep the bus while the ir latches
            ctrl.ir_write = 1'b1;
            step_next     = 3'd2;
          end
          default: begin
            ctrl.pcsel = control_pkg::PCSEL_INC;
            state_next = control_pkg::EVAL;
            step_next  = '0;
          end
        endcase
      end
      control_pkg::EVAL: begin
        ctrl.alu_func = decode.alu_func;
        case (decode.cls)
          control_pkg::NOP: done = 1'b1;
          control_pkg::CMP: begin
            ctrl.ccr_write = 1'b1;
            done           = 1'b1;
          end
          control_pkg::MOV, control_pkg::COM, control_pkg::NEG,
          control_pkg::LDIS, control_pkg::LDIU: begin
            case (decode.cls)
              control_pkg::MOV:  ctrl.regsel = control_pkg::REGSEL_REG2;
              control_pkg::COM:  ctrl.regsel = control_pkg::REGSEL_COM;
              control_pkg::NEG:  ctrl.regsel = control_pkg::REGSEL_NEG;
              control_pkg::LDIS: ctrl.regsel = control_pkg::REGSEL_IMMS;
              default:           ctrl.regsel = control_pkg::REGSEL_IMMU;
            endcase
            ctrl.reg_write = control_pkg::REG_WRITE_DW;
            done           = 1'b1;
          end
          control_pkg::BRANCH: begin
            if (taken)
              ctrl.pcsel = control_pkg::PCSEL_REL;
            done = 1'b1;
          end
          control_pkg::INC, control_pkg::DEC, control_pkg::ALU3: begin
            if (decode.cls == control_pkg::ALU3) begin
              ctrl.reg_read_addr1 = fields.rb;  // ra <= rb op rc
              ctrl.reg_read_addr2 = fields.rc;
            end else begin
              ctrl.alu2sel = control_pkg::ALU2SEL_ONE;
            end
            if (step == 3'd0) begin
              step_next = 3'd1;  // aluval settles
            end else begin
              ctrl.reg_write = control_pkg::REG_WRITE_DW;
              done           = 1'b1;
            end
          end
          control_pkg::LDA, control_pkg::JMP: begin
            ctrl.reg_read_addr1 = fields.rb;
            ctrl.alu2sel        = control_pkg::ALU2SEL_IND;  // rb + offset
            if (step == 3'd0)
              step_next = 3'd1;
            else if (decode.cls == control_pkg::LDA) begin
              ctrl.reg_write = control_pkg::REG_WRITE_DW;
              done           = 1'b1;
            end else begin
              ctrl.pcsel = control_pkg::PCSEL_ALU;
              done       = 1'b1;
            end
          end
          control_pkg::LOAD, control_pkg::STORE: begin
            bus.addrsel = 1'b1;  // address from mar
            case (step)
              3'd0: begin
                ctrl.reg_read_addr1 = fields.rb;
                ctrl.alu2sel        = control_pkg::ALU2SEL_IND;
                step_next           = 3'd1;
              end
              3'd1: begin
                ctrl.marsel = control_pkg::MARSEL_ALU;
                step_next   = 3'd2;
              end
              3'd2: begin
                bus.read       = (decode.cls == control_pkg::LOAD);
                bus.write      = (decode.cls == control_pkg::STORE);
                bus.byteenable = lanes;
                ctrl.mdrsel    = (decode.cls == control_pkg::LOAD) ?
                                 control_pkg::MDRSEL_BUS : control_pkg::MDRSEL_REG;
                if (!bus_wait)
                  step_next = 3'd3;
              end
              default: begin
                if (decode.cls == control_pkg::LOAD) begin
                  ctrl.regsel    = control_pkg::REGSEL_MDR;  // ra <= mdr
                  ctrl.reg_write = control_pkg::REG_WRITE_DW;
                end
                done = 1'b1;
              end
            endcase
          end
          default: begin
            state_next = control_pkg::FAULT;  // undefined encoding
            step_next  = '0;
          end
        endcase
      end
      default: state_next = control_pkg::FAULT;  // stays here until reset
    endcase

    if (done) begin
      state_next = control_pkg::FETCH;
      step_next  = '0;
    end
  end

endmodule

//--- src/branch_condition.sv
`timescale 1ns/1ns

module branch_condition (
  input  isa_pkg::cond_t cond,
  input  isa_pkg::ccr_t  ccr,
  output logic           taken
);

  logic carry, negative, overflow, zero;
  logic lt_signed;

  assign {carry, negative, overflow, zero} = ccr;
  assign lt_signed = negative ^ overflow;  // signed less-than after cmp

  always_comb begin
    case (cond)
      isa_pkg::COND_BRA:  taken = 1'b1;
      isa_pkg::COND_BEQ:  taken = zero;
      isa_pkg::COND_BNE:  taken = ~zero;
      isa_pkg::COND_BGTU: taken = ~(zero | carry);
      isa_pkg::COND_BGT:  taken = ~(zero | lt_signed);
      isa_pkg::COND_BGE:  taken = ~lt_signed;
      isa_pkg::COND_BLE:  taken = zero | lt_signed;
      isa_pkg::COND_BLT:  taken = lt_signed;
      isa_pkg::COND_BGEU: taken = ~carry;
      isa_pkg::COND_BLTU: taken = carry;
      isa_pkg::COND_BLEU: taken = carry | zero;
      default:            taken = 1'b0;  // brn, never
    endcase
  end

endmodule

//--- src/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
  input  isa_pkg::instr_fields_t fields,
  output control_pkg::decode_t   decode
);

  always_comb begin
    decode.cls  = control_pkg::UNDEF;
    decode.size = control_pkg::LONG;
    decode.cond = fields.op[3:0];

    case (fields.mode)
      isa_pkg::MODE_REG: begin
        case (fields.op)
          isa_pkg::OP_NOP: decode.cls = control_pkg::NOP;
          isa_pkg::OP_CMP: decode.cls = control_pkg::CMP;
          isa_pkg::OP_INC: decode.cls = control_pkg::INC;
          isa_pkg::OP_DEC: decode.cls = control_pkg::DEC;
          isa_pkg::OP_MOV: decode.cls = control_pkg::MOV;
          isa_pkg::OP_COM: decode.cls = control_pkg::COM;
          isa_pkg::OP_NEG: decode.cls = control_pkg::NEG;
          default: begin
            if (fields.op[7:4] == isa_pkg::OP_ALU3_HI)
              decode.cls = control_pkg::ALU3;
          end
        endcase
      end
      isa_pkg::MODE_IMM: begin
        if (fields.op[7:4] == 4'h0 && fields.op[3:0] <= isa_pkg::COND_BRN)
          decode.cls = control_pkg::BRANCH;
        else if (fields.op == isa_pkg::OP_LDIS)
          decode.cls = control_pkg::LDIS;
        else if (fields.op == isa_pkg::OP_LDIU)
          decode.cls = control_pkg::LDIU;
      end
      isa_pkg::MODE_REGIND: begin
        case (fields.op)
          isa_pkg::OP_LDA: decode.cls = control_pkg::LDA;
          isa_pkg::OP_JMP: decode.cls = control_pkg::JMP;
          isa_pkg::OP_ST_L, isa_pkg::OP_ST_H, isa_pkg::OP_ST_B:
            decode.cls = control_pkg::STORE;
          isa_pkg::OP_LD_L, isa_pkg::OP_LD_H, isa_pkg::OP_LD_B:
            decode.cls = control_pkg::LOAD;
          default: decode.cls = control_pkg::UNDEF;
        endcase
        case (fields.op[2:1])  // width pairs: long, half, byte
          2'b01: decode.size = control_pkg::HALF;
          2'b10: decode.size = control_pkg::BYTE;
          default: decode.size = control_pkg::LONG;
        endcase
      end
      default: decode.cls = control_pkg::UNDEF;  // includes the old direct mode
    endcase

    case (decode.cls)
      control_pkg::ALU3: decode.alu_func = fields.op[2:0];
      control_pkg::CMP, control_pkg::DEC: decode.alu_func = control_pkg::ALU_SUB;
      default: decode.alu_func = control_pkg::ALU_ADD;
    endcase
  end

endmodule

//--- src/instr_register.sv
`timescale 1ns/1ns

module instr_register (
  input  logic                   clock,
  input  logic                   reset_n,
  input  isa_pkg::word_t         bus_rdata,
  input  logic                   ir_write,
  output isa_pkg::instr_fields_t fields
);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      fields <= '0;
    end else if (ir_write) begin  // one-cycle strobe from fetch step 1
      fields.mode <= bus_rdata[31:29];
      fields.op   <= bus_rdata[28:21];
      fields.ra   <= bus_rdata[20:16];
      fields.rb   <= bus_rdata[15:11];
      fields.rc   <= bus_rdata[10:6];
    end
  end

endmodule

//--- src/control_pkg.sv
package control_pkg;

  typedef logic [2:0] alu_func_t;
  typedef logic [2:0] alu2sel_t;
  typedef logic [3:0] regsel_t;
  typedef logic [2:0] mdrsel_t;
  typedef logic [1:0] marsel_t;
  typedef logic [2:0] pcsel_t;
  typedef logic [1:0] reg_write_t;
  typedef logic [3:0] byteen_t;
  typedef logic [1:0] align_t;
  typedef logic [2:0] step_t;

  localparam alu_func_t ALU_ADD = 3'd2;
  localparam alu_func_t ALU_SUB = 3'd3;

  localparam alu2sel_t ALU2SEL_REG = 3'd0;  // reg_data_out2
  localparam alu2sel_t ALU2SEL_IND = 3'd1;  // ir offset
  localparam alu2sel_t ALU2SEL_ONE = 3'd2;

  localparam regsel_t REGSEL_ALU  = 4'd0;
  localparam regsel_t REGSEL_MDR  = 4'd1;
  localparam regsel_t REGSEL_NEG  = 4'd2;
  localparam regsel_t REGSEL_COM  = 4'd3;
  localparam regsel_t REGSEL_REG2 = 4'd4;
  localparam regsel_t REGSEL_IMMS = 4'd5;  // sign-extended 16 bit
  localparam regsel_t REGSEL_IMMU = 4'd6;  // zero-extended 16 bit

  localparam mdrsel_t MDRSEL_HOLD = 3'd0;
  localparam mdrsel_t MDRSEL_BUS  = 3'd1;
  localparam mdrsel_t MDRSEL_REG  = 3'd3;

  localparam marsel_t MARSEL_HOLD = 2'd0;
  localparam marsel_t MARSEL_ALU  = 2'd2;

  localparam pcsel_t PCSEL_HOLD   = 3'd0;
  localparam pcsel_t PCSEL_INC    = 3'd1;
  localparam pcsel_t PCSEL_MAR    = 3'd2;
  localparam pcsel_t PCSEL_REL    = 3'd3;
  localparam pcsel_t PCSEL_ALU    = 3'd4;
  localparam pcsel_t PCSEL_VECTOR = 3'd5;

  localparam reg_write_t REG_WRITE_NONE = 2'b00;
  localparam reg_write_t REG_WRITE_DW   = 2'b11;

  typedef enum logic [3:0] {
    NOP, CMP, INC, DEC, MOV, COM, NEG, ALU3,
    BRANCH, LDIS, LDIU, LDA, JMP, LOAD, STORE, UNDEF
  } instr_class_t;

  typedef enum logic [1:0] {LONG, HALF, BYTE} size_t;

  typedef struct packed {
    instr_class_t   cls;
    size_t          size;
    isa_pkg::cond_t cond;
    alu_func_t      alu_func;
  } decode_t;

  typedef struct packed {
    logic             ir_write;
    logic             ccr_write;
    alu_func_t        alu_func;
    alu2sel_t         alu2sel;
    regsel_t          regsel;
    isa_pkg::reg_idx_t reg_read_addr1;
    isa_pkg::reg_idx_t reg_read_addr2;
    isa_pkg::reg_idx_t reg_write_addr;
    reg_write_t       reg_write;
    mdrsel_t          mdrsel;
    marsel_t          marsel;
    pcsel_t           pcsel;
  } ctrl_word_t;

  typedef struct packed {
    logic    read;
    logic    write;
    logic    addrsel;     // 0 pc, 1 mar
    byteen_t byteenable;
  } bus_req_t;

  typedef enum logic [1:0] {RESET, FETCH, EVAL, FAULT} ctrl_state_t;

endpackage

//--- src/isa_pkg.sv
package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [2:0]  mode_t;
  typedef logic [7:0]  opcode_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  ccr_t;    // carry, negative, overflow, zero
  typedef logic [3:0]  cond_t;   // low opcode nibble of a branch

  typedef struct packed {
    mode_t    mode;  // ir[31:29]
    opcode_t  op;    // ir[28:21]
    reg_idx_t ra;    // ir[20:16]
    reg_idx_t rb;    // ir[15:11]
    reg_idx_t rc;    // ir[10:6]
  } instr_fields_t;

  localparam mode_t MODE_REG    = 3'd0;
  localparam mode_t MODE_REGIND = 3'd1;
  localparam mode_t MODE_IMM    = 3'd2;

  // register mode
  localparam opcode_t OP_NOP = 8'h00;
  localparam opcode_t OP_CMP = 8'h02;
  localparam opcode_t OP_INC = 8'h03;
  localparam opcode_t OP_DEC = 8'h04;
  localparam opcode_t OP_MOV = 8'h07;
  localparam opcode_t OP_COM = 8'h08;
  localparam opcode_t OP_NEG = 8'h09;
  localparam logic [3:0] OP_ALU3_HI = 4'h2;  // 0x2x group, func in op[2:0]

  // immediate mode, branches occupy 0x00..0x0b
  localparam opcode_t OP_LDIS = 8'h0c;
  localparam opcode_t OP_LDIU = 8'h0d;

  // register-indirect mode, op[0] set means load
  localparam opcode_t OP_ST_L = 8'h00;
  localparam opcode_t OP_LD_L = 8'h01;
  localparam opcode_t OP_ST_H = 8'h02;
  localparam opcode_t OP_LD_H = 8'h03;
  localparam opcode_t OP_ST_B = 8'h04;
  localparam opcode_t OP_LD_B = 8'h05;
  localparam opcode_t OP_LDA  = 8'h0a;
  localparam opcode_t OP_JMP  = 8'h0b;

  localparam cond_t COND_BRA  = 4'h0;
  localparam cond_t COND_BEQ  = 4'h1;
  localparam cond_t COND_BNE  = 4'h2;
  localparam cond_t COND_BGTU = 4'h3;
  localparam cond_t COND_BGT  = 4'h4;
  localparam cond_t COND_BGE  = 4'h5;
  localparam cond_t COND_BLE  = 4'h6;
  localparam cond_t COND_BLT  = 4'h7;
  localparam cond_t COND_BGEU = 4'h8;
  localparam cond_t COND_BLTU = 4'h9;
  localparam cond_t COND_BLEU = 4'ha;
  localparam cond_t COND_BRN  = 4'hb;  // highest branch code

endpackage
